// ==== tb.f ====
logic/soc_map_pkg.sv
logic/soc_pad_pkg.sv
logic/sync_2ff.sv
logic/apb_access_decode.sv
logic/soc_ctrl_regs.sv
logic/read_result_mux.sv
logic/soc_ctrl_top.sv
dv/soc_ctrl_properties.sv
dv/tb_soc_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_soc_ctrl
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -Wno-fatal -f $(FILELIST) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_soc_ctrl.sv ====
// Needs a simulator with timing support; expects soc_ctrl_properties bound into the DUT as u_props
`timescale 1ns/10ps

module tb_soc_ctrl;

  import soc_map_pkg::*;
  import soc_pad_pkg::*;

  localparam int CLK_PERIOD    = 40;
  localparam int RESET_CYCLES  = 4;
  localparam int PREADY_LIMIT  = 8;    // Access phase to PREADY, with slack
  localparam int N_ACCESSES    = 120;  // Rough count of APB transfers over all tests
  localparam int ACCESS_CYCLES = 4;
  localparam int WAIT_CYCLES   = 250;  // Idle waits, watchdog and timeout runs
  localparam int TIMEOUT_NS    =
    2 * (RESET_CYCLES + N_ACCESSES * ACCESS_CYCLES + WAIT_CYCLES) * CLK_PERIOD;
  localparam logic [15:0] LFSR_SEED = 16'd51559;
  localparam logic [31:0] BOOT_ADDR = 32'h1C00_8000;
  localparam logic [31:0] WD_SHORT  = 32'd40;
  localparam logic [31:0] RTO_PROG  = 32'h0000_0025;

  logic                              HCLK;
  logic                              HRESETn;
  logic [ADDR_W-1:0]                 paddr;
  logic [31:0]                       pwdata, prdata;
  logic                              pwrite, psel, penable, pready, pslverr;
  logic                              bootsel, dmactive, stoptimer, wd_expired;
  logic [N_IO-1:0][PADCFG_W-1:0]     pad_cfg;
  logic [N_IO-1:0][PADMUX_W-1:0]     pad_mux;
  logic [JTAG_W-1:0]                 jtag_in, jtag_out;
  logic [31:0]                       fc_bootaddr;
  logic                              fc_fetchen, rto, start_rto, soft_reset;
  logic [NB_MASTER-1:0]              peripheral_rto;
  logic [PADCFG_W-1:0]               exp_cfg [N_IO];  // Reference pad model
  logic [PADMUX_W-1:0]               exp_mux [N_IO];
  logic [15:0]                       lfsr;

  soc_ctrl_top uut (
    .HCLK, .HRESETn, .paddr_i(paddr), .pwdata_i(pwdata), .pwrite_i(pwrite),
    .psel_i(psel), .penable_i(penable), .prdata_o(prdata), .pready_o(pready),
    .pslverr_o(pslverr), .bootsel_i(bootsel), .dmactive_i(dmactive),
    .stoptimer_i(stoptimer), .wd_expired_o(wd_expired), .pad_cfg_o(pad_cfg),
    .pad_mux_o(pad_mux), .soc_jtag_reg_i(jtag_in), .soc_jtag_reg_o(jtag_out),
    .fc_bootaddr_o(fc_bootaddr), .fc_fetchen_o(fc_fetchen), .rto_o(rto),
    .start_rto_i(start_rto), .peripheral_rto_i(peripheral_rto), .soft_reset_o(soft_reset)
  );

  initial begin
    HCLK = 1'b0;
    forever #(CLK_PERIOD / 2) HCLK = ~HCLK;
  end

  task automatic stop_fail(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  initial begin
    #(TIMEOUT_NS);
    stop_fail("Timeout: the tests did not finish in the expected time");
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
      else stop_fail($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_bus(input string name, input logic [N_IO*PADCFG_W-1:0] got,
                           input logic [N_IO*PADCFG_W-1:0] exp);
    assert (got === exp)
      else stop_fail($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else stop_fail(what);
  endtask

  // Galois form, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};  // One LFSR step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [ADDR_W-1:0] pad_addr(input int idx);
    return PAD_WIN_BASE + ADDR_W'(idx * 4);
  endfunction

  function automatic logic [N_IO*PADCFG_W-1:0] cfg_bus();
    logic [N_IO*PADCFG_W-1:0] v;
    for (int i = 0; i < N_IO; i++)
      v[i*PADCFG_W +: PADCFG_W] = exp_cfg[i];
    return v;
  endfunction

  function automatic logic [31:0] mux_bus();
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < N_IO; i++)
      v[i*PADMUX_W +: PADMUX_W] = exp_mux[i];
    return v;
  endfunction

  task automatic reset_pad_model();
    for (int i = 0; i < N_IO; i++) begin
      exp_cfg[i] = PADCFG_RST;
      exp_mux[i] = '0;
    end
  endtask

  // Setup phase, access phase, then hold until PREADY is seen on a falling edge
  task automatic apb_access(input logic write, input logic [ADDR_W-1:0] addr,
                            input logic [31:0] data, input logic exp_err,
                            output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(negedge HCLK);
    psel   = 1'b1;
    pwrite = write;
    paddr  = addr;
    pwdata = data;
    @(negedge HCLK);
    penable = 1'b1;
    while (!pready && waited < PREADY_LIMIT) begin
      @(negedge HCLK);
      waited++;
    end
    check_true(pready, $sformatf("No PREADY for the access to 0x%h", addr));
    rdata = prdata;
    check_eq("pslverr_o", 32'(pslverr), 32'(exp_err));
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, 1'b0, unused);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [31:0] data);
    apb_access(1'b0, addr, 32'd0, 1'b0, data);
  endtask

  task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [31:0] exp,
                            input string name);
    logic [31:0] got;
    apb_read(addr, got);
    check_eq(name, got, exp);
  endtask

  task automatic test_reset_values();
    check_bus("pad_cfg_o", pad_cfg, cfg_bus());
    check_eq("pad_mux_o", pad_mux, mux_bus());
    check_eq("fc_bootaddr_o", fc_bootaddr, BOOTADDR_RST);
    check_eq("fc_fetchen_o", 32'(fc_fetchen), 32'(FETCHEN_RST));
    check_eq("pready_o pslverr_o wd_expired_o rto_o soft_reset_o",
             32'({pready, pslverr, wd_expired, rto, soft_reset}), 32'd0);
    read_check(REG_INFO, 32'(N_CORES * 65536 + N_CLUSTERS), "INFO");
    read_check(REG_FCBOOT, BOOTADDR_RST, "FCBOOT");
    read_check(REG_FCFETCH, 32'(FETCHEN_RST), "FCFETCH");
    read_check(REG_WD_COUNT, 32'(WD_COUNT_RST), "WD_COUNT");
    read_check(REG_WD_CONTROL, 32'(WD_COUNT_RST), "WD_CONTROL");  // Disabled, full count
    read_check(REG_RESET_REASON, 32'd1, "RESET_REASON");
    read_check(REG_RESET_REASON, 32'd0, "RESET_REASON after read");
    read_check(REG_RTO_COUNT, 32'(RTO_COUNT_RST), "RTO_COUNT");
    read_check(REG_RTO_PERIPH, 32'd0, "RTO_PERIPH");
    read_check(REG_BOOTSEL, 32'({dmactive, bootsel}), "BOOTSEL");
  endtask

  task automatic test_boot_jtag();
    apb_write(REG_FCBOOT, BOOT_ADDR);
    read_check(REG_FCBOOT, BOOT_ADDR, "FCBOOT");
    check_eq("fc_bootaddr_o", fc_bootaddr, BOOT_ADDR);
    apb_write(REG_FCFETCH, 32'd0);
    check_eq("fc_fetchen_o", 32'(fc_fetchen), 32'd0);
    apb_write(REG_FCFETCH, 32'd1);
    check_eq("fc_fetchen_o", 32'(fc_fetchen), 32'd1);
    read_check(REG_FCFETCH, 32'd1, "FCFETCH");
    jtag_in = 8'h3C;
    apb_write(REG_JTAGREG, 32'h0000_00A5);
    check_eq("soc_jtag_reg_o", 32'(jtag_out), 32'h0000_00A5);
    read_check(REG_JTAGREG, 32'h0000_3CA5, "JTAGREG");  // Input byte above output byte
  endtask

  task automatic test_pads();
    logic [31:0]          r;
    logic [PAD_IDX_W-1:0] p;
    logic [PADCFG_W-1:0]  c;
    logic [PADMUX_W-1:0]  m;
    for (int k = 0; k < 8; k++) begin
      rand_bits(PAD_IDX_W, r);
      p = r[PAD_IDX_W-1:0];
      rand_bits(PADCFG_W, r);
      c = r[PADCFG_W-1:0];
      rand_bits(PADMUX_W, r);
      m = r[PADMUX_W-1:0];
      if (k % 2 == 0) apb_write(pad_addr(int'(p)), {18'd0, c, 6'd0, m});
      else apb_write(REG_WCFGFUN, {2'd0, c, 6'd0, m, 12'd0, p});
      exp_cfg[p] = c;
      exp_mux[p] = m;
    end
    check_bus("pad_cfg_o", pad_cfg, cfg_bus());
    check_eq("pad_mux_o", pad_mux, mux_bus());
    for (int i = 0; i < N_IO; i++) begin
      read_check(pad_addr(i), {18'd0, exp_cfg[i], 6'd0, exp_mux[i]},
                 $sformatf("pad %0d window", i));
      apb_write(REG_RCFGFUN, 32'(i));
      read_check(REG_RCFGFUN, {2'd0, exp_cfg[i], 6'd0, exp_mux[i], 12'd0, 4'(i)},
                 $sformatf("RCFGFUN pad %0d", i));
    end
    read_check(pad_addr(N_IO + 4), BAD_PAD_DATA, "pad window past N_IO");
    apb_write(pad_addr(N_IO), 32'h0000_0A02);  // Must not touch pad 0
    check_bus("pad_cfg_o", pad_cfg, cfg_bus());
    check_eq("pad_mux_o", pad_mux, mux_bus());
  endtask

  task automatic test_unmapped();
    logic [31:0] rdata;
    apb_access(1'b0, 12'h100, 32'd0, 1'b1, rdata);
    check_eq("prdata_o", rdata, BAD_ADDR_DATA);
    apb_access(1'b1, 12'h0F0, 32'hFFFF_FFFF, 1'b1, rdata);
    read_check(REG_FCBOOT, BOOT_ADDR, "FCBOOT after bad write");
    read_check(REG_RTO_COUNT, 32'(RTO_COUNT_RST), "RTO_COUNT after bad write");
    check_bus("pad_cfg_o", pad_cfg, cfg_bus());
  endtask

  task automatic test_watchdog();
    logic [31:0] before_kick;
    logic [31:0] after_kick;
    logic [31:0] frozen;
    int          cycles;
    apb_write(REG_WD_COUNT, WD_SHORT);
    read_check(REG_WD_COUNT, WD_SHORT, "WD_COUNT");
    apb_write(REG_WD_CONTROL, 32'h8000_0000);
    apb_write(REG_WD_COUNT, 32'd99);  // Locked once enabled
    read_check(REG_WD_COUNT, WD_SHORT, "WD_COUNT while enabled");
    repeat (8) @(negedge HCLK);
    apb_read(REG_WD_CONTROL, before_kick);
    check_true(before_kick[31] && before_kick[30:0] < WD_SHORT[30:0],
               "Watchdog is not enabled or is not counting down");
    apb_write(REG_WD_CONTROL, 32'(WD_KICK_KEY));
    apb_read(REG_WD_CONTROL, after_kick);
    check_true(after_kick[30:0] > before_kick[30:0], "Watchdog kick did not reload the count");
    stoptimer = 1'b1;
    apb_read(REG_WD_CONTROL, frozen);
    repeat (10) @(negedge HCLK);
    read_check(REG_WD_CONTROL, frozen, "WD_CONTROL while stopped");
    stoptimer = 1'b0;
    cycles = 0;
    while (!wd_expired && cycles < int'(WD_SHORT) + 8) begin
      @(negedge HCLK);
      cycles++;
    end
    check_true(wd_expired, "Watchdog did not expire after the count ran out");
    read_check(REG_RESET_REASON, 32'd2, "RESET_REASON after expiry");
    read_check(REG_RESET_REASON, 32'd0, "RESET_REASON after read");
  endtask

  task automatic test_rto_soft_reset();
    logic [31:0] rto_val;
    int          cycles;
    rto_val = (RTO_PROG & 32'h000F_FFF0) | 32'h0000_000F;  // Low nibble reads as ones
    apb_write(REG_RTO_COUNT, RTO_PROG);
    read_check(REG_RTO_COUNT, rto_val, "RTO_COUNT");
    start_rto = 1'b1;
    cycles = 0;
    while (!rto && cycles < 2 * int'(rto_val)) begin
      @(negedge HCLK);
      cycles++;
    end
    check_eq("cycles to rto_o", 32'(cycles), rto_val + 32'd1);
    start_rto = 1'b0;
    peripheral_rto = 4'b0101;
    @(negedge HCLK);
    peripheral_rto = 4'b0000;
    read_check(REG_RTO_PERIPH, 32'h5, "RTO_PERIPH");
    peripheral_rto = 4'b0010;
    @(negedge HCLK);
    peripheral_rto = 4'b0000;
    read_check(REG_RTO_PERIPH, 32'h7, "RTO_PERIPH sticky");
    apb_write(REG_RTO_PERIPH, 32'd0);
    read_check(REG_RTO_PERIPH, 32'd0, "RTO_PERIPH cleared");
    peripheral_rto = 4'b1000;
    @(negedge HCLK);
    peripheral_rto = 4'b0000;
    apb_write(REG_SOFT_RESET, 32'd1);
    check_eq("soft_reset_o", 32'(soft_reset), 32'd1);
    @(negedge HCLK);
    check_eq("soft_reset_o", 32'(soft_reset), 32'd0);
    reset_pad_model();
    check_bus("pad_cfg_o", pad_cfg, cfg_bus());
    check_eq("pad_mux_o", pad_mux, mux_bus());
    read_check(REG_RTO_COUNT, 32'(RTO_COUNT_RST), "RTO_COUNT after soft reset");
    read_check(REG_RTO_PERIPH, 32'd0, "RTO_PERIPH after soft reset");
  endtask

  initial begin
    HRESETn        = 1'b0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    bootsel        = 1'b1;
    dmactive       = 1'b0;
    stoptimer      = 1'b0;
    jtag_in        = '0;
    start_rto      = 1'b0;
    peripheral_rto = '0;
    lfsr           = LFSR_SEED;
    reset_pad_model();
    repeat (RESET_CYCLES) @(negedge HCLK);
    HRESETn = 1'b1;
    test_reset_values();
    test_boot_jtag();
    test_pads();
    test_unmapped();
    test_watchdog();
    test_rto_soft_reset();
    if (uut.u_props.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
      $finish;
    end else begin
      stop_fail("Bound protocol assertions failed during the run");
    end
  end

endmodule

// ==== dv/soc_ctrl_properties.sv ====
// Bound into soc_ctrl_top; relies on the internal rd and wr strobe names of the top level
`timescale 1ns/10ps

module soc_ctrl_properties (
  input logic HCLK,
  input logic HRESETn,
  input logic pready_i,
  input logic pslverr_i,
  input logic wd_expired_i,
  input logic rd_i,
  input logic wr_i
);

  int fail_count = 0;  // Sampled by the testbench at the end

  pready_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pready_i |=> !pready_i)
    else begin
      fail_count++;
      $error("PREADY stayed high for more than one cycle");
    end

  pslverr_with_pready: assert property (@(posedge HCLK) disable iff (!HRESETn)
    pslverr_i |-> pready_i)
    else begin
      fail_count++;
      $error("PSLVERR high without PREADY");
    end

  wd_expired_pulse: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wd_expired_i |=> !wd_expired_i)
    else begin
      fail_count++;
      $error("Watchdog expiry longer than one cycle");
    end

  strobes_exclusive: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !(rd_i && wr_i))
    else begin
      fail_count++;
      $error("Read and write strobes high together");
    end

endmodule

bind soc_ctrl_top soc_ctrl_properties u_props (
  .HCLK, .HRESETn, .pready_i(pready_o), .pslverr_i(pslverr_o),
  .wd_expired_i(wd_expired_o), .rd_i(rd), .wr_i(wr)
);

// ==== logic/soc_ctrl_top.sv ====
// APB slave on HCLK; bootsel, dmactive and the JTAG input are asynchronous and synchronized here
`timescale 1ns/10ps

module soc_ctrl_top (
  input  logic                                     HCLK,
  input  logic                                     HRESETn,
  input  logic [soc_map_pkg::ADDR_W-1:0]           paddr_i,
  input  logic [31:0]                              pwdata_i,
  input  logic                                     pwrite_i,
  input  logic                                     psel_i,
  input  logic                                     penable_i,
  output logic [31:0]                              prdata_o,
  output logic                                     pready_o,
  output logic                                     pslverr_o,
  input  logic                                     bootsel_i,
  input  logic                                     dmactive_i,
  input  logic                                     stoptimer_i,
  output logic                                     wd_expired_o,
  output logic [soc_pad_pkg::N_IO-1:0][soc_pad_pkg::PADCFG_W-1:0] pad_cfg_o,
  output logic [soc_pad_pkg::N_IO-1:0][soc_pad_pkg::PADMUX_W-1:0] pad_mux_o,
  input  logic [soc_map_pkg::JTAG_W-1:0]           soc_jtag_reg_i,
  output logic [soc_map_pkg::JTAG_W-1:0]           soc_jtag_reg_o,
  output logic [31:0]                              fc_bootaddr_o,
  output logic                                     fc_fetchen_o,
  output logic                                     rto_o,
  input  logic                                     start_rto_i,
  input  logic [soc_map_pkg::NB_MASTER-1:0]        peripheral_rto_i,
  output logic                                     soft_reset_o
);

  import soc_map_pkg::*;
  import soc_pad_pkg::*;

  logic                 wr, rd, rr_clear, wd_en;
  reg_sel_e             sel;
  pad_idx_t             pad;
  logic [31:0]          wdata;
  logic [JTAG_W-1:0]    jtag_sync;
  logic [1:0]           strap, reset_reason;
  logic [PAD_IDX_W-1:0] io_pad;
  logic [PADCFG_W-1:0]  pad_rd_cfg;
  logic [PADMUX_W-1:0]  pad_rd_mux;
  logic [WD_W-1:0]      wd_count, wd_cur;
  logic [RTO_W-1:0]     rto_count;
  logic [NB_MASTER-1:0] periph_rto;

  sync_2ff #(.T(logic [JTAG_W-1:0])) u_jtag_sync (
    .HCLK, .HRESETn, .d_i(soc_jtag_reg_i), .q_o(jtag_sync)
  );

  sync_2ff #(.T(logic [1:0])) u_strap_sync (
    .HCLK, .HRESETn, .d_i({dmactive_i, bootsel_i}), .q_o(strap)
  );

  apb_access_decode u_decode (
    .HCLK, .HRESETn, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i,
    .wr_o(wr), .rd_o(rd), .sel_o(sel), .pad_o(pad), .wdata_o(wdata)
  );

  soc_ctrl_regs u_regs (
    .HCLK, .HRESETn, .wr_i(wr), .rd_i(rd), .sel_i(sel), .pad_i(pad), .wdata_i(wdata),
    .rr_clear_i(rr_clear), .stoptimer_i, .start_rto_i, .peripheral_rto_i,
    .pad_cfg_o, .pad_mux_o, .jtag_reg_o(soc_jtag_reg_o), .fc_bootaddr_o, .fc_fetchen_o,
    .wd_expired_o, .rto_o, .soft_reset_o, .io_pad_o(io_pad), .pad_rd_cfg_o(pad_rd_cfg),
    .pad_rd_mux_o(pad_rd_mux), .wd_count_o(wd_count), .wd_cur_o(wd_cur), .wd_en_o(wd_en),
    .reset_reason_o(reset_reason), .rto_count_o(rto_count), .periph_rto_o(periph_rto)
  );

  read_result_mux u_result (
    .HCLK, .HRESETn, .rd_i(rd), .wr_i(wr), .sel_i(sel), .pad_i(pad), .io_pad_i(io_pad),
    .pad_rd_cfg_i(pad_rd_cfg), .pad_rd_mux_i(pad_rd_mux), .jtag_reg_i(soc_jtag_reg_o),
    .bootaddr_i(fc_bootaddr_o), .fetchen_i(fc_fetchen_o), .wd_count_i(wd_count),
    .wd_cur_i(wd_cur), .wd_en_i(wd_en), .reset_reason_i(reset_reason),
    .rto_count_i(rto_count), .periph_rto_i(periph_rto), .jtag_sync_i(jtag_sync),
    .strap_i(strap), .prdata_o, .pready_o, .pslverr_o, .rr_clear_o(rr_clear)
  );

endmodule

// ==== logic/read_result_mux.sv ====
// PRDATA updates on reads only; write responses keep the last read data on the bus
`timescale 1ns/10ps

module read_result_mux (
  input  logic                              HCLK,
  input  logic                              HRESETn,
  input  logic                              rd_i,
  input  logic                              wr_i,
  input  soc_map_pkg::reg_sel_e             sel_i,
  input  soc_pad_pkg::pad_idx_t             pad_i,
  input  logic [soc_pad_pkg::PAD_IDX_W-1:0] io_pad_i,
  input  logic [soc_pad_pkg::PADCFG_W-1:0]  pad_rd_cfg_i,
  input  logic [soc_pad_pkg::PADMUX_W-1:0]  pad_rd_mux_i,
  input  logic [soc_map_pkg::JTAG_W-1:0]    jtag_reg_i,
  input  logic [31:0]                       bootaddr_i,
  input  logic                              fetchen_i,
  input  logic [soc_map_pkg::WD_W-1:0]      wd_count_i,
  input  logic [soc_map_pkg::WD_W-1:0]      wd_cur_i,
  input  logic                              wd_en_i,
  input  logic [1:0]                        reset_reason_i,
  input  logic [soc_map_pkg::RTO_W-1:0]     rto_count_i,
  input  logic [soc_map_pkg::NB_MASTER-1:0] periph_rto_i,
  input  logic [soc_map_pkg::JTAG_W-1:0]    jtag_sync_i,
  input  logic [1:0]                        strap_i,
  output logic [31:0]                       prdata_o,
  output logic                              pready_o,
  output logic                              pslverr_o,
  output logic                              rr_clear_o
);

  import soc_map_pkg::*;
  import soc_pad_pkg::*;

  logic [31:0] rdata;

  always_comb begin
    rdata = '0;
    case (sel_i)
      SEL_INFO:    rdata = {16'(N_CORES), 16'(N_CLUSTERS)};
      SEL_FCBOOT:  rdata = bootaddr_i;
      SEL_FCFETCH: rdata = 32'(fetchen_i);
      SEL_WCFGFUN, SEL_RCFGFUN: begin
        rdata[0 +: PAD_IDX_W]  = io_pad_i;
        rdata[16 +: PADMUX_W]  = pad_rd_mux_i;
        rdata[24 +: PADCFG_W]  = pad_rd_cfg_i;
      end
      SEL_JTAGREG:      rdata = 32'({jtag_sync_i, jtag_reg_i});  // Input above output
      SEL_BOOTSEL:      rdata = 32'(strap_i);  // {dmactive, bootsel}
      SEL_WD_COUNT:     rdata = {1'b0, wd_count_i};
      SEL_WD_CONTROL:   rdata = {wd_en_i, wd_cur_i};
      SEL_RESET_REASON: rdata = 32'(reset_reason_i);
      SEL_RTO_PERIPH:   rdata = 32'(periph_rto_i);
      SEL_RTO_COUNT:    rdata = 32'(rto_count_i);
      SEL_PAD_WIN: begin
        if (pad_i < PAD_WIN_W'(N_IO)) begin
          rdata[8 +: PADCFG_W] = pad_rd_cfg_i;
          rdata[0 +: PADMUX_W] = pad_rd_mux_i;
        end else begin
          rdata = BAD_PAD_DATA;  // No error response here
        end
      end
      SEL_NONE: rdata = BAD_ADDR_DATA;
      default:  rdata = '0;  // Soft reset reads as zero
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      pready_o   <= 1'b0;
      pslverr_o  <= 1'b0;
      rr_clear_o <= 1'b0;
    end else begin
      pready_o   <= rd_i || wr_i;
      pslverr_o  <= (rd_i || wr_i) && (sel_i == SEL_NONE);
      rr_clear_o <= rd_i && (sel_i == SEL_RESET_REASON);  // Clears after the response
    end
  end

  always_ff @(posedge HCLK) begin
    if (rd_i) prdata_o <= rdata;
  end

endmodule

// ==== logic/soc_ctrl_regs.sv ====
// Single clock domain; the watchdog count wraps after expiry unless it is kicked again
`timescale 1ns/10ps

module soc_ctrl_regs (
  input  logic                                     HCLK,
  input  logic                                     HRESETn,
  input  logic                                     wr_i,
  input  logic                                     rd_i,
  input  soc_map_pkg::reg_sel_e                    sel_i,
  input  soc_pad_pkg::pad_idx_t                    pad_i,
  input  logic [31:0]                              wdata_i,
  input  logic                                     rr_clear_i,
  input  logic                                     stoptimer_i,
  input  logic                                     start_rto_i,
  input  logic [soc_map_pkg::NB_MASTER-1:0]        peripheral_rto_i,
  output logic [soc_pad_pkg::N_IO-1:0][soc_pad_pkg::PADCFG_W-1:0] pad_cfg_o,
  output logic [soc_pad_pkg::N_IO-1:0][soc_pad_pkg::PADMUX_W-1:0] pad_mux_o,
  output logic [soc_map_pkg::JTAG_W-1:0]           jtag_reg_o,
  output logic [31:0]                              fc_bootaddr_o,
  output logic                                     fc_fetchen_o,
  output logic                                     wd_expired_o,
  output logic                                     rto_o,
  output logic                                     soft_reset_o,
  output logic [soc_pad_pkg::PAD_IDX_W-1:0]        io_pad_o,
  output logic [soc_pad_pkg::PADCFG_W-1:0]         pad_rd_cfg_o,
  output logic [soc_pad_pkg::PADMUX_W-1:0]         pad_rd_mux_o,
  output logic [soc_map_pkg::WD_W-1:0]             wd_count_o,
  output logic [soc_map_pkg::WD_W-1:0]             wd_cur_o,
  output logic                                     wd_en_o,
  output logic [1:0]                               reset_reason_o,
  output logic [soc_map_pkg::RTO_W-1:0]            rto_count_o,
  output logic [soc_map_pkg::NB_MASTER-1:0]        periph_rto_o
);

  import soc_map_pkg::*;
  import soc_pad_pkg::*;

  logic                 pad_ok;
  logic [PAD_IDX_W-1:0] win_idx;
  logic [PAD_IDX_W-1:0] wcfg_idx;
  logic [PAD_IDX_W-1:0] rd_idx;
  logic                 wd_reload;
  logic [RTO_W-1:0]     rto_cnt;

  assign pad_ok   = pad_i < PAD_WIN_W'(N_IO);
  assign win_idx  = pad_i[PAD_IDX_W-1:0];
  assign wcfg_idx = wdata_i[PAD_IDX_W-1:0];

  // Window accesses read the addressed pad, the indirect pair reads the select
  assign rd_idx       = (sel_i == SEL_PAD_WIN) ? win_idx : io_pad_o;
  assign pad_rd_cfg_o = pad_cfg_o[rd_idx];
  assign pad_rd_mux_o = pad_mux_o[rd_idx];

  assign wd_reload = wr_i && (sel_i == SEL_WD_CONTROL) &&
                     (wdata_i[31] || (wd_en_o && wdata_i[15:0] == WD_KICK_KEY));

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      io_pad_o      <= '0;
      pad_cfg_o     <= {N_IO{PADCFG_RST}};
      pad_mux_o     <= '0;
      jtag_reg_o    <= '0;
      fc_bootaddr_o <= BOOTADDR_RST;
      fc_fetchen_o  <= FETCHEN_RST;
      rto_count_o   <= RTO_COUNT_RST;
      periph_rto_o  <= '0;
      soft_reset_o  <= 1'b0;
    end else begin
      soft_reset_o <= 1'b0;
      periph_rto_o <= periph_rto_o | peripheral_rto_i;  // Sticky until cleared
      if (rd_i && sel_i == SEL_PAD_WIN && pad_ok) io_pad_o <= win_idx;
      if (wr_i) begin
        case (sel_i)
          SEL_FCBOOT:  fc_bootaddr_o <= wdata_i;
          SEL_FCFETCH: fc_fetchen_o  <= wdata_i[0];
          SEL_WCFGFUN: begin
            io_pad_o            <= wcfg_idx;
            pad_cfg_o[wcfg_idx] <= wdata_i[24 +: PADCFG_W];
            pad_mux_o[wcfg_idx] <= wdata_i[16 +: PADMUX_W];
          end
          SEL_RCFGFUN:    io_pad_o     <= wcfg_idx;
          SEL_JTAGREG:    jtag_reg_o   <= wdata_i[JTAG_W-1:0];
          SEL_RTO_PERIPH: periph_rto_o <= '0;
          SEL_RTO_COUNT:  rto_count_o  <= {wdata_i[RTO_W-1:4], 4'hF};  // Low nibble forced
          SEL_SOFT_RESET: begin
            soft_reset_o <= 1'b1;
            io_pad_o     <= '0;
            pad_cfg_o    <= {N_IO{PADCFG_RST}};
            pad_mux_o    <= '0;
            rto_count_o  <= RTO_COUNT_RST;
            periph_rto_o <= '0;
          end
          SEL_PAD_WIN: begin
            if (pad_ok) begin  // Pads past N_IO are ignored
              io_pad_o           <= win_idx;
              pad_cfg_o[win_idx] <= wdata_i[8 +: PADCFG_W];
              pad_mux_o[win_idx] <= wdata_i[0 +: PADMUX_W];
            end
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wd_en_o        <= 1'b0;
      wd_count_o     <= WD_COUNT_RST;
      wd_cur_o       <= WD_COUNT_RST;
      wd_expired_o   <= 1'b0;
      reset_reason_o <= RR_POWER_ON;
    end else begin
      wd_expired_o <= 1'b0;
      if (wr_i && sel_i == SEL_WD_COUNT && !wd_en_o) wd_count_o <= wdata_i[WD_W-1:0];
      if (wr_i && sel_i == SEL_WD_CONTROL && wdata_i[31]) wd_en_o <= 1'b1;  // No disable path
      if (wd_reload) begin
        wd_cur_o <= wd_count_o;
      end else if (wd_en_o && !stoptimer_i) begin
        wd_cur_o     <= wd_cur_o - WD_W'(1);
        wd_expired_o <= (wd_cur_o == WD_W'(1));
      end
      if (wd_expired_o) reset_reason_o <= RR_WATCHDOG;
      else if (rr_clear_i) reset_reason_o <= 2'b00;  // Clear on read
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      rto_cnt <= RTO_COUNT_RST;
      rto_o   <= 1'b0;
    end else begin
      if (start_rto_i) rto_cnt <= rto_cnt - RTO_W'(1);
      else rto_cnt <= rto_count_o;
      rto_o <= (rto_cnt == '0);
    end
  end

endmodule

// ==== logic/apb_access_decode.sv ====
// Fixed three-cycle APB schedule; addresses decode on exact match, no byte strobes
`timescale 1ns/10ps

module apb_access_decode (
  input  logic                             HCLK,
  input  logic                             HRESETn,
  input  logic [soc_map_pkg::ADDR_W-1:0]   paddr_i,
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [31:0]                      pwdata_i,
  output logic                             wr_o,
  output logic                             rd_o,
  output soc_map_pkg::reg_sel_e            sel_o,
  output soc_pad_pkg::pad_idx_t            pad_o,
  output logic [31:0]                      wdata_o
);

  import soc_map_pkg::*;
  import soc_pad_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_WAIT} state_e;

  state_e   state;
  reg_sel_e sel_d;
  logic     take;

  assign take = (state == ST_IDLE) && psel_i && penable_i;  // Access phase seen

  always_comb begin
    sel_d = SEL_NONE;
    if (paddr_i[ADDR_W-1:10] == PAD_WIN_BASE[ADDR_W-1:10]) begin
      sel_d = SEL_PAD_WIN;
    end else begin
      case (paddr_i)
        REG_INFO:         sel_d = SEL_INFO;
        REG_FCBOOT:       sel_d = SEL_FCBOOT;
        REG_FCFETCH:      sel_d = SEL_FCFETCH;
        REG_WCFGFUN:      sel_d = SEL_WCFGFUN;
        REG_RCFGFUN:      sel_d = SEL_RCFGFUN;
        REG_JTAGREG:      sel_d = SEL_JTAGREG;
        REG_BOOTSEL:      sel_d = SEL_BOOTSEL;
        REG_WD_COUNT:     sel_d = SEL_WD_COUNT;
        REG_WD_CONTROL:   sel_d = SEL_WD_CONTROL;
        REG_RESET_REASON: sel_d = SEL_RESET_REASON;
        REG_RTO_PERIPH:   sel_d = SEL_RTO_PERIPH;
        REG_RTO_COUNT:    sel_d = SEL_RTO_COUNT;
        REG_SOFT_RESET:   sel_d = SEL_SOFT_RESET;
        default:          sel_d = SEL_NONE;
      endcase
    end
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state <= ST_IDLE;
      wr_o  <= 1'b0;
      rd_o  <= 1'b0;
      sel_o <= SEL_NONE;
    end else begin
      wr_o <= take && pwrite_i;
      rd_o <= take && !pwrite_i;
      if (take) sel_o <= sel_d;
      case (state)
        ST_IDLE:   if (take) state <= ST_ACCESS;
        ST_ACCESS: state <= ST_WAIT;  // Bank and result stage act here
        default:   state <= ST_IDLE;  // Skip the edge where PSEL is still held
      endcase
    end
  end

  always_ff @(posedge HCLK) begin
    if (take) begin
      pad_o   <= paddr_i[2 +: PAD_WIN_W];
      wdata_o <= pwdata_i;
    end
  end

endmodule

// ==== logic/sync_2ff.sv ====
// Only for slowly changing level signals; a multi-bit payload is not sampled coherently
`timescale 1ns/10ps

module sync_2ff #(
  parameter type T = logic
) (
  input  logic HCLK,
  input  logic HRESETn,
  input  T     d_i,
  output T     q_o
);

  T meta;  // First stage, may go metastable

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      meta <= '0;
      q_o  <= '0;
    end else begin
      meta <= d_i;
      q_o  <= meta;
    end
  end

endmodule

// ==== logic/soc_pad_pkg.sv ====
// Pad geometry; N_IO must not exceed 2**PAD_IDX_W and the window decodes 256 slots
package soc_pad_pkg;

  localparam int N_IO      = 16;
  localparam int PADCFG_W  = 6;
  localparam int PADMUX_W  = 2;
  localparam int PAD_IDX_W = 4;  // Width of the pad select register

  // The window index is wider than the pad select so that
  // out-of-range pads in the 0x400 window stay visible
  localparam int PAD_WIN_W = 8;

  typedef logic [PAD_WIN_W-1:0] pad_idx_t;

  localparam logic [PADCFG_W-1:0] PADCFG_RST = {PADCFG_W{1'b1}};

endpackage

// ==== logic/soc_map_pkg.sv ====
// Register map of the 4 KB APB slave; offsets are byte addresses and word aligned
package soc_map_pkg;

  localparam int ADDR_W = 12;

  localparam logic [ADDR_W-1:0] REG_INFO         = 12'h000;  // Cores and clusters
  localparam logic [ADDR_W-1:0] REG_FCBOOT       = 12'h004;
  localparam logic [ADDR_W-1:0] REG_FCFETCH      = 12'h008;
  localparam logic [ADDR_W-1:0] REG_WCFGFUN      = 12'h060;  // Indirect pad write
  localparam logic [ADDR_W-1:0] REG_RCFGFUN      = 12'h064;  // Indirect pad select
  localparam logic [ADDR_W-1:0] REG_JTAGREG      = 12'h074;
  localparam logic [ADDR_W-1:0] REG_BOOTSEL      = 12'h0C4;
  localparam logic [ADDR_W-1:0] REG_WD_COUNT     = 12'h0D0;
  localparam logic [ADDR_W-1:0] REG_WD_CONTROL   = 12'h0D4;
  localparam logic [ADDR_W-1:0] REG_RESET_REASON = 12'h0D8;
  localparam logic [ADDR_W-1:0] REG_RTO_PERIPH   = 12'h0E0;
  localparam logic [ADDR_W-1:0] REG_RTO_COUNT    = 12'h0E4;
  localparam logic [ADDR_W-1:0] REG_SOFT_RESET   = 12'h0FC;
  localparam logic [ADDR_W-1:0] PAD_WIN_BASE     = 12'h400;  // Direct pad window up to 0x7FC

  typedef enum logic [3:0] {
    SEL_INFO, SEL_FCBOOT, SEL_FCFETCH, SEL_WCFGFUN, SEL_RCFGFUN,
    SEL_JTAGREG, SEL_BOOTSEL, SEL_WD_COUNT, SEL_WD_CONTROL,
    SEL_RESET_REASON, SEL_RTO_PERIPH, SEL_RTO_COUNT, SEL_SOFT_RESET,
    SEL_PAD_WIN, SEL_NONE
  } reg_sel_e;

  localparam int WD_W  = 31;  // Watchdog count width
  localparam int RTO_W = 20;  // Ready-timeout count width

  localparam logic [31:0]      BOOTADDR_RST  = 32'h1A00_0080;
  localparam logic             FETCHEN_RST   = 1'b1;
  localparam logic [WD_W-1:0]  WD_COUNT_RST  = 31'd32768;
  localparam logic [RTO_W-1:0] RTO_COUNT_RST = 20'h000FF;
  localparam logic [1:0]       RR_POWER_ON   = 2'd1;  // Reset reason codes
  localparam logic [1:0]       RR_WATCHDOG   = 2'd2;
  localparam logic [15:0]      WD_KICK_KEY   = 16'h6699;

  localparam int N_CORES    = 4;
  localparam int N_CLUSTERS = 1;
  localparam int NB_MASTER  = 4;
  localparam int JTAG_W     = 8;

  localparam logic [31:0] BAD_ADDR_DATA = 32'hDEAD_BEEF;
  localparam logic [31:0] BAD_PAD_DATA  = 32'h0095_BEEF;

endpackage
